/* Makefile */
# The instruction ROM loads program.hex from the working directory,
# so the simulation binary runs inside dv/.

.PHONY: sim clean

sim:
	verilator --binary --top-module cpuTb -f list.f -o VcpuTb
	cd dv && ../obj_dir/VcpuTb

clean:
	rm -rf obj_dir

/* dv/clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    output logic Clk
);

    // 10 ns period, first rising edge at 5 ns
    initial begin
        Clk = 1'b0;
        forever begin
            #5 Clk = ~Clk;
        end
    end

endmodule

`default_nettype wire

/* dv/cpuTb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  regAddr;
        logic [31:0] value;
    } retire_t;

    localparam int ResetCycles  = 8;
    localparam int DrainCycles  = 10;
    localparam int CyclesPerRet = 8;
    localparam int CycleSlack   = 40;

    logic        Clk;
    logic        reset;
    logic [31:0] pcDisplay;
    logic [31:0] writeDataDisplay;
    logic [4:0]  writeRegDisplay;
    logic        displayValid;

    retire_t     expected [$];
    int          checked;
    int          cycles;
    int          drained;
    int          cycleLimit;
    int unsigned idleCycles;

    clockGen clkGen0 (.Clk);

    cpuTop dut0 (
        .Clk, .reset,
        .pcDisplay, .writeDataDisplay, .writeRegDisplay, .displayValid
    );

    ////////////////////
    // Reporting

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] want);
        if (actual !== want) begin
            abortRun($sformatf("Fail at %0t: %s is %h, expected %h",
                               $time, name, actual, want));
        end
    endtask

    ////////////////////
    // Expected retirements for program.hex

    task automatic addEntry(input logic [31:0] pc, input logic [4:0] regAddr,
                            input logic [31:0] value);
        retire_t entry;
        entry.pc      = pc;
        entry.regAddr = regAddr;
        entry.value   = value;
        expected.push_back(entry);
    endtask

    task automatic loadTable();
        addEntry(32'h00, 5'd1,  32'h0000_0005);
        // Negative immediate is sign extended
        addEntry(32'h04, 5'd2,  32'hffff_fffd);
        addEntry(32'h08, 5'd3,  32'h0000_0002);
        addEntry(32'h0c, 5'd4,  32'h0000_0008);
        // Producer of $3 still in memory stage
        addEntry(32'h10, 5'd5,  32'h0000_0007);
        addEntry(32'h14, 5'd6,  32'h0000_0005);
        addEntry(32'h18, 5'd7,  32'h0000_0001);
        addEntry(32'h1c, 5'd8,  32'h0000_0050);
        // sw at 0x20 writes no register
        addEntry(32'h24, 5'd9,  32'h0000_0002);
        addEntry(32'h28, 5'd10, 32'h0000_0004);
        // beq skips 0x30
        // bne at 0x34 falls through
        addEntry(32'h38, 5'd12, 32'h0000_0007);
        // j at 0x3c skips 0x40
        // jal links to 0x48
        addEntry(32'h44, 5'd31, 32'h0000_0048);
        addEntry(32'h50, 5'd16, 32'h0000_0049);
    endtask

    ////////////////////
    // Main sequence

    initial begin
        reset   = 1'b1;
        checked = 0;
        cycles  = 0;
        drained = 0;
        loadTable();
        cycleLimit = expected.size() * CyclesPerRet + CycleSlack;

        void'($urandom(32'h192b969e));
        idleCycles = $urandom_range(3, 0);

        // Nothing may retire while reset is held
        repeat (ResetCycles - 1) begin
            @(negedge Clk);
            checkValue("displayValid", {31'd0, displayValid}, 32'd0);
        end
        @(posedge Clk);
        reset <= 1'b0;

        // Idle cycles after reset, still before the first retirement
        repeat (idleCycles) begin
            @(negedge Clk);
            cycles++;
            checkValue("displayValid", {31'd0, displayValid}, 32'd0);
        end

        while (checked < expected.size() || drained < DrainCycles) begin
            @(negedge Clk);
            cycles++;
            if (cycles > cycleLimit) begin
                abortRun($sformatf("Timeout after %0d cycles, only %0d of %0d retirements seen",
                                   cycles, checked, expected.size()));
            end
            if (checked == expected.size()) begin
                drained++;
            end
            if (displayValid === 1'b1) begin
                if (checked >= expected.size()) begin
                    abortRun($sformatf("Unexpected retirement at %0t from pc %h",
                                       $time, pcDisplay));
                end else begin
                    checkValue("pcDisplay", pcDisplay, expected[checked].pc);
                    checkValue("writeRegDisplay", {27'd0, writeRegDisplay},
                               {27'd0, expected[checked].regAddr});
                    checkValue("writeDataDisplay", writeDataDisplay,
                               expected[checked].value);
                    checked++;
                end
            end else if (displayValid !== 1'b0) begin
                abortRun($sformatf("displayValid is unknown at %0t", $time));
            end
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/program.hex */
// One instruction word per line, loaded from address 0
// Columns: hex word, then byte address and assembly
20010005 // 00 addi $1, $0, 5
2002fffd // 04 addi $2, $0, -3
00221820 // 08 add  $3, $1, $2
00222022 // 0c sub  $4, $1, $2
00612825 // 10 or   $5, $3, $1
00223024 // 14 and  $6, $1, $2
0041382a // 18 slt  $7, $2, $1
00014100 // 1c sll  $8, $1, 4
ac030008 // 20 sw   $3, 8($0)
8c090008 // 24 lw   $9, 8($0)
01295020 // 28 add  $10, $9, $9
10210001 // 2c beq  $1, $1, 1
200b0063 // 30 addi $11, $0, 99
14210001 // 34 bne  $1, $1, 1
200c0007 // 38 addi $12, $0, 7
08000011 // 3c j    0x44
200d0063 // 40 addi $13, $0, 99
0c000014 // 44 jal  0x50
200e0063 // 48 addi $14, $0, 99
200f0063 // 4c addi $15, $0, 99
23f00001 // 50 addi $16, $31, 1
08000015 // 54 j    0x54
00000000 // 58 nop
00000000 // 5c nop
00000000 // 60 nop
00000000 // 64 nop
00000000 // 68 nop
00000000 // 6c nop

/* list.f */
rtl/mipsPkg.sv
rtl/stageReg.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/cpuTop.sv
dv/clockGen.sv
dv/cpuTb.sv

/* rtl/cpuTop.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTop import mipsPkg::*; (
    input  logic        Clk,
    input  logic        reset,
    output logic [31:0] pcDisplay,
    output logic [31:0] writeDataDisplay,
    output logic [4:0]  writeRegDisplay,
    output logic        displayValid
);

    ifId_t       fetchOut;
    ifId_t       fdOut;
    idEx_t       decodeOut;
    idEx_t       deOut;
    exMem_t      executeOut;
    exMem_t      emOut;
    memWb_t      memoryOut;
    memWb_t      mwOut;
    regWrite_t   wbWrite;
    logic        stall;
    logic        redirect;
    logic [31:0] target;
    logic [5:0]  exDest;
    logic [5:0]  memDest;
    logic [31:0] wbData;

    ////////////////////
    // Fetch and decode

    fetchStage fetch0 (
        .Clk, .reset, .stall, .redirect, .target,
        .fetched(fetchOut)
    );

    stageReg #(.payload_t(ifId_t)) regFD (
        .Clk, .reset,
        .hold(stall), .bubble(redirect),
        .d(fetchOut), .q(fdOut)
    );

    // Destinations still in flight, for the hazard check
    assign exDest  = {deOut.ctrl.regWrite, deOut.writeReg};
    assign memDest = {emOut.ctrl.regWrite, emOut.writeReg};

    decodeStage decode0 (
        .Clk,
        .fetched(fdOut),
        .exDest, .memDest, .wbWrite,
        .decoded(decodeOut),
        .stall, .redirect, .target
    );

    stageReg #(.payload_t(idEx_t)) regDE (
        .Clk, .reset,
        .hold(1'b0), .bubble(stall),
        .d(decodeOut), .q(deOut)
    );

    ////////////////////
    // Execute and memory

    executeStage execute0 (.decoded(deOut), .executed(executeOut));

    stageReg #(.payload_t(exMem_t)) regEM (
        .Clk, .reset,
        .hold(1'b0), .bubble(1'b0),
        .d(executeOut), .q(emOut)
    );

    memoryStage memory0 (.Clk, .executed(emOut), .loaded(memoryOut));

    stageReg #(.payload_t(memWb_t)) regMW (
        .Clk, .reset,
        .hold(1'b0), .bubble(1'b0),
        .d(memoryOut), .q(mwOut)
    );

    ////////////////////
    // Writeback

    always_comb begin
        if (mwOut.ctrl.link) begin
            wbData = mwOut.pc + 32'd4;
        end else if (mwOut.ctrl.memToReg) begin
            wbData = mwOut.loadData;
        end else begin
            wbData = mwOut.aluResult;
        end
    end

    assign wbWrite.enable  = mwOut.ctrl.regWrite && mwOut.writeReg != 5'd0;
    assign wbWrite.regAddr = mwOut.writeReg;
    assign wbWrite.data    = wbData;

    // Display trails the register write by one cycle
    always_ff @(posedge Clk) begin
        if (reset) begin
            pcDisplay        <= '0;
            writeDataDisplay <= '0;
            writeRegDisplay  <= '0;
            displayValid     <= 1'b0;
        end else begin
            displayValid <= wbWrite.enable;
            if (wbWrite.enable) begin
                pcDisplay        <= mwOut.pc;
                writeDataDisplay <= wbData;
                writeRegDisplay  <= mwOut.writeReg;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStage import mipsPkg::*; (
    input  logic        Clk,
    input  ifId_t       fetched,
    input  logic [5:0]  exDest,
    input  logic [5:0]  memDest,
    input  regWrite_t   wbWrite,
    output idEx_t       decoded,
    output logic        stall,
    output logic        redirect,
    output logic [31:0] target
);

    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [31:0] imm;
    logic [31:0] pcPlus4;
    logic [31:0] rsData;
    logic [31:0] rtData;
    logic [31:0] regs [32];
    ctrl_t       ctrl;
    logic [4:0]  writeReg;
    logic        usesRt;
    logic        operandsEqual;
    logic        taken;

    assign opcode  = fetched.instr[31:26];
    assign rs      = fetched.instr[25:21];
    assign rt      = fetched.instr[20:16];
    assign rd      = fetched.instr[15:11];
    assign imm     = {{16{fetched.instr[15]}}, fetched.instr[15:0]};
    assign pcPlus4 = fetched.pc + 32'd4;

    ////////////////////
    // Controller

    always_comb begin
        ctrl     = '0;
        writeReg = rt;
        usesRt   = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                ctrl.regWrite = 1'b1;
                writeReg      = rd;
                usesRt        = 1'b1;
            end
            OP_ADDI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            OP_LW: begin
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            OP_SW: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                usesRt        = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                usesRt = 1'b1;
            end
            OP_JAL: begin
                ctrl.regWrite = 1'b1;
                ctrl.link     = 1'b1;
                writeReg      = 5'd31;
            end
            default: begin
                // j and unknown opcodes write nothing
                ctrl = '0;
            end
        endcase
        ctrl.aluOp = ALU_ADD;
    end

    ////////////////////
    // Register file, write before read

    always_ff @(posedge Clk) begin
        if (wbWrite.enable && wbWrite.regAddr != 5'd0) begin
            regs[wbWrite.regAddr] <= wbWrite.data;
        end
    end

    assign rsData = (rs == 5'd0) ? '0 :
                    (wbWrite.enable && wbWrite.regAddr == rs) ? wbWrite.data : regs[rs];
    assign rtData = (rt == 5'd0) ? '0 :
                    (wbWrite.enable && wbWrite.regAddr == rt) ? wbWrite.data : regs[rt];

    ////////////////////
    // Hazard stall, no forwarding

    function automatic logic hits(logic [4:0] src, logic [5:0] dest);
        return dest[5] && dest[4:0] != 5'd0 && dest[4:0] == src;
    endfunction

    always_comb begin
        stall = 1'b0;
        // Jumps read no registers
        if (opcode != OP_J && opcode != OP_JAL) begin
            stall = hits(rs, exDest) || hits(rs, memDest);
        end
        if (usesRt) begin
            stall = stall || hits(rt, exDest) || hits(rt, memDest);
        end
    end

    ////////////////////
    // Branch and jump resolution

    assign operandsEqual = (rsData == rtData);

    always_comb begin
        taken  = 1'b0;
        target = pcPlus4 + {imm[29:0], 2'b00};
        case (opcode)
            OP_BEQ:      taken = operandsEqual;
            OP_BNE:      taken = !operandsEqual;
            OP_J, OP_JAL: begin
                taken  = 1'b1;
                target = {pcPlus4[31:28], fetched.instr[25:0], 2'b00};
            end
            default:     taken = 1'b0;
        endcase
    end

    assign redirect = taken && !stall;

    always_comb begin
        decoded.pc        = fetched.pc;
        decoded.ctrl      = ctrl;
        decoded.readData1 = rsData;
        decoded.readData2 = rtData;
        decoded.imm       = imm;
        decoded.shamt     = fetched.instr[10:6];
        decoded.funct     = fetched.instr[5:0];
        decoded.writeReg  = writeReg;
    end

endmodule

`default_nettype wire

/* rtl/executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStage import mipsPkg::*; (
    input  idEx_t  decoded,
    output exMem_t executed
);

    aluOp_t      op;
    logic        isRtype;
    logic [31:0] srcA;
    logic [31:0] srcB;
    logic [31:0] result;

    // Only R-type writes a register from two register operands
    assign isRtype = decoded.ctrl.regWrite && !decoded.ctrl.aluSrc && !decoded.ctrl.link;

    ////////////////////
    // ALU control

    always_comb begin
        op = decoded.ctrl.aluOp;
        if (isRtype) begin
            case (decoded.funct)
                FN_ADD:  op = ALU_ADD;
                FN_SUB:  op = ALU_SUB;
                FN_AND:  op = ALU_AND;
                FN_OR:   op = ALU_OR;
                FN_SLT:  op = ALU_SLT;
                FN_SLL:  op = ALU_SLL;
                default: op = ALU_ADD;
            endcase
        end
    end

    ////////////////////
    // ALU

    assign srcA = decoded.readData1;
    assign srcB = decoded.ctrl.aluSrc ? decoded.imm : decoded.readData2;

    always_comb begin
        case (op)
            ALU_ADD: result = srcA + srcB;
            ALU_SUB: result = srcA - srcB;
            ALU_AND: result = srcA & srcB;
            ALU_OR:  result = srcA | srcB;
            ALU_SLT: result = {31'd0, $signed(srcA) < $signed(srcB)};
            // Shifts rt, not rs
            ALU_SLL: result = decoded.readData2 << decoded.shamt;
            default: result = srcA + srcB;
        endcase
    end

    always_comb begin
        executed.pc        = decoded.pc;
        executed.ctrl      = decoded.ctrl;
        executed.aluResult = result;
        executed.storeData = decoded.readData2;
        executed.writeReg  = decoded.writeReg;
    end

endmodule

`default_nettype wire

/* rtl/fetchStage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchStage import mipsPkg::*; (
    input  logic        Clk,
    input  logic        reset,
    input  logic        stall,
    input  logic        redirect,
    input  logic [31:0] target,
    output ifId_t       fetched
);

    logic [31:0] pc;
    logic [31:0] pcNext;
    logic [31:0] imem [IMEM_DEPTH];

    initial begin
        $readmemh(PROGRAM_FILE, imem);
    end

    ////////////////////
    // Next PC

    always_comb begin
        if (stall) begin
            pcNext = pc;
        end else if (redirect) begin
            pcNext = target;
        end else begin
            pcNext = pc + 32'd4;
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    ////////////////////
    // Instruction ROM, word addressed

    always_comb begin
        fetched.pc    = pc;
        fetched.instr = imem[pc[7:2]];
    end

endmodule

`default_nettype wire

/* rtl/memoryStage.sv */
`timescale 1ns/1ps
`default_nettype none

module memoryStage import mipsPkg::*; (
    input  logic   Clk,
    input  exMem_t executed,
    output memWb_t loaded
);

    logic [31:0] dmem [DMEM_DEPTH];
    logic [5:0]  wordAddr;
    logic [31:0] readWord;

    // Word addressed, low two bits ignored
    assign wordAddr = executed.aluResult[7:2];

    ////////////////////
    // Data memory

    always_ff @(posedge Clk) begin
        if (executed.ctrl.memWrite) begin
            dmem[wordAddr] <= executed.storeData;
        end
    end

    // Asynchronous read
    assign readWord = executed.ctrl.memRead ? dmem[wordAddr] : '0;

    always_comb begin
        loaded.pc        = executed.pc;
        loaded.ctrl      = executed.ctrl;
        loaded.aluResult = executed.aluResult;
        loaded.loadData  = readWord;
        loaded.writeReg  = executed.writeReg;
    end

endmodule

`default_nettype wire

/* rtl/mipsPkg.sv */
`default_nettype none

package mipsPkg;

    ////////////////////
    // Memory sizes and program image

    localparam int IMEM_DEPTH = 64;
    localparam int DMEM_DEPTH = 64;
    localparam PROGRAM_FILE = "program.hex";

    ////////////////////
    // Primary opcodes, bits [31:26]

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_JAL   = 6'h03;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // R-type function codes, bits [5:0]
    localparam logic [5:0] FN_SLL = 6'h00;
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_SLL
    } aluOp_t;

    ////////////////////
    // Pipeline payloads

    typedef struct packed {
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   memToReg;
        logic   aluSrc;
        // jal writes pc + 4
        logic   link;
        aluOp_t aluOp;
    } ctrl_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
    } ifId_t;

    typedef struct packed {
        logic [31:0] pc;
        ctrl_t       ctrl;
        logic [31:0] readData1;
        logic [31:0] readData2;
        logic [31:0] imm;
        logic [4:0]  shamt;
        logic [5:0]  funct;
        logic [4:0]  writeReg;
    } idEx_t;

    typedef struct packed {
        logic [31:0] pc;
        ctrl_t       ctrl;
        logic [31:0] aluResult;
        logic [31:0] storeData;
        logic [4:0]  writeReg;
    } exMem_t;

    typedef struct packed {
        logic [31:0] pc;
        ctrl_t       ctrl;
        logic [31:0] aluResult;
        logic [31:0] loadData;
        logic [4:0]  writeReg;
    } memWb_t;

    // Writeback port into the register file
    typedef struct packed {
        logic        enable;
        logic [4:0]  regAddr;
        logic [31:0] data;
    } regWrite_t;

endpackage

`default_nettype wire

/* rtl/stageReg.sv */
`timescale 1ns/1ps
`default_nettype none

module stageReg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     Clk,
    input  logic     reset,
    input  logic     hold,
    input  logic     bubble,
    input  payload_t d,
    output payload_t q
);

    // All zeros is a bubble for every payload
    always_ff @(posedge Clk) begin
        if (reset) begin
            q <= '0;
        end else if (!hold) begin
            if (bubble) begin
                q <= '0;
            end else begin
                q <= d;
            end
        end
    end

endmodule

`default_nettype wire
